//--- include/viterbiSync_config.svh
`ifndef VITERBI_SYNC_CONFIG_SVH
`define VITERBI_SYNC_CONFIG_SVH

// Signed demodulator symbol width
`define SYM_WIDTH   18

// Hard-decision soft values that are bitwise inverses of each other
`define SOFT_WIDTH  3
`define SOFT_NEG    2
`define SOFT_POS    5

// Decoder error count width
`define BER_WIDTH   16

// SPRT lock detector
`define SPRT_START  64
`define SPRT_LIMIT  128
`define SPRT_STEP   8

`endif

//--- src/viterbiSyncPkg.sv
`include "viterbiSync_config.svh"

package viterbiSyncPkg;

    typedef enum logic {
        MODE_BPSK,
        MODE_QPSK
    } demodMode_t;

    // Alignment hypothesis advanced by one on every slip
    typedef enum logic [2:0] {
        STEP0,
        STEP1,
        STEP2,
        STEP3,
        STEP4,
        STEP5,
        STEP6,
        STEP7
    } syncStep_t;

    typedef struct packed {
        logic signed [`SYM_WIDTH-1:0] i;
        logic signed [`SYM_WIDTH-1:0] q;
    } symbol_t;

    // One rate-1/2 code branch per rail
    typedef struct packed {
        logic [`SOFT_WIDTH-1:0] iG1;
        logic [`SOFT_WIDTH-1:0] iG2;
        logic [`SOFT_WIDTH-1:0] qG1;
        logic [`SOFT_WIDTH-1:0] qG2;
    } branchPair_t;

    typedef struct packed {
        logic                  done;
        logic [`BER_WIDTH-1:0] count;
    } errReport_t;

endpackage

//--- src/branchAligner.sv
`timescale 1ns/1ns

`include "viterbiSync_config.svh"

module branchAligner
    import viterbiSyncPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  demodMode_t  i_mode,
    input  symbol_t     i_sym,
    input  logic        i_symEn,
    input  logic        i_slip,
    output branchPair_t o_pair,
    output logic        o_pairValid,
    output syncStep_t   o_step
);

    logic [`SOFT_WIDTH-1:0] iSoft;
    logic [`SOFT_WIDTH-1:0] qSoft;
    logic [`SOFT_WIDTH-1:0] iSoftPrev;
    logic [`SOFT_WIDTH-1:0] g1;
    logic [`SOFT_WIDTH-1:0] g2;
    logic                   codeEn;
    logic                   pairDone;
    logic                   slipPending;
    logic                   stepAllowed;
    logic                   doStep;

    // Hard-decision slicer on the sign bits
    always_comb begin
        if (i_sym.i[`SYM_WIDTH-1]) begin
            iSoft = `SOFT_WIDTH'(`SOFT_NEG);
        end
        else begin
            iSoft = `SOFT_WIDTH'(`SOFT_POS);
        end
        if (i_sym.q[`SYM_WIDTH-1]) begin
            qSoft = `SOFT_WIDTH'(`SOFT_NEG);
        end
        else begin
            qSoft = `SOFT_WIDTH'(`SOFT_POS);
        end
    end

    // Previous I value is G1 of a BPSK branch
    always_ff @(posedge clk) begin
        if (i_symEn) begin
            iSoftPrev <= iSoft;
        end
    end

    // Code phase
    always_ff @(posedge clk) begin
        if (reset) begin
            codeEn <= 1'b0;
        end
        else if (i_mode == MODE_QPSK) begin
            codeEn <= 1'b1;
        end
        else if (i_symEn) begin
            codeEn <= ~codeEn;
        end
    end

    // Branch mapping for the current step
    always_comb begin
        g1 = iSoft;
        g2 = qSoft;
        pairDone = 1'b0;
        if (i_mode == MODE_QPSK) begin
            pairDone = i_symEn;
            case (o_step[1:0])
                2'd0: begin
                    g1 = iSoft;
                    g2 = qSoft;
                end
                2'd1: begin
                    g1 = qSoft;
                    g2 = ~iSoft;
                end
                2'd2: begin
                    g1 = ~iSoft;
                    g2 = ~qSoft;
                end
                default: begin
                    g1 = ~qSoft;
                    g2 = iSoft;
                end
            endcase
        end
        else begin
            // Odd steps take the pair on the other code phase
            pairDone = i_symEn && (codeEn != o_step[0]);
            if (o_step[1]) begin
                g1 = ~iSoftPrev;
                g2 = ~iSoft;
            end
            else begin
                g1 = iSoftPrev;
                g2 = iSoft;
            end
        end
        // Upper four steps invert G2
        if (o_step[2]) begin
            g2 = ~g2;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_pairValid <= 1'b0;
        end
        else begin
            o_pairValid <= pairDone;
        end
    end

    // Only the I branch feeds the decoder here
    always_ff @(posedge clk) begin
        if (pairDone) begin
            o_pair <= '{iG1: g1, iG2: g2, qG1: '0, qG2: '0};
        end
    end

    // A BPSK step must land on the G1 phase
    assign stepAllowed = i_symEn && ((i_mode == MODE_QPSK) || codeEn);
    assign doStep      = stepAllowed && (slipPending || i_slip);

    always_ff @(posedge clk) begin
        if (reset) begin
            o_step      <= STEP0;
            slipPending <= 1'b0;
        end
        else begin
            slipPending <= (slipPending || i_slip) && !doStep;
            if (doStep) begin
                o_step <= syncStep_t'(o_step + 3'd1);
            end
        end
    end

    pairNeedsStrobe: assert property (
        @(posedge clk) disable iff (reset)
        $rose(o_pairValid) |-> $past(i_symEn)
    ) else $error("o_pairValid rose without a symbol strobe");

    modeStable: assert property (
        @(posedge clk) disable iff (reset)
        $stable(i_mode)
    ) else $error("i_mode changed outside reset");

endmodule

//--- src/sprtLockDetector.sv
`timescale 1ns/1ns

`include "viterbiSync_config.svh"

module sprtLockDetector
    import viterbiSyncPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  errReport_t i_err,
    output logic       o_inSync,
    output logic       o_slip
);

    // One extra bit so the full error count compares as positive
    localparam int ACC_WIDTH = `BER_WIDTH + 1;
    localparam logic signed [ACC_WIDTH-1:0] ACC_START = ACC_WIDTH'(`SPRT_START);
    localparam logic signed [ACC_WIDTH-1:0] ACC_LIMIT = ACC_WIDTH'(`SPRT_LIMIT);
    localparam logic signed [ACC_WIDTH-1:0] ACC_STEP  = ACC_WIDTH'(`SPRT_STEP);

    logic signed [ACC_WIDTH-1:0] sprtAccum;
    logic signed [ACC_WIDTH-1:0] errCount;

    assign errCount = $signed({1'b0, i_err.count});

    always_ff @(posedge clk) begin
        if (reset) begin
            sprtAccum <= ACC_START;
            o_inSync  <= 1'b0;
            o_slip    <= 1'b0;
        end
        else begin
            o_slip <= 1'b0;
            if (i_err.done) begin
                if (i_err.count != '0) begin
                    if (sprtAccum >= errCount) begin
                        sprtAccum <= sprtAccum - errCount;
                    end
                    else begin
                        // Too many errors for this hypothesis
                        sprtAccum <= ACC_START;
                        o_inSync  <= 1'b0;
                        o_slip    <= 1'b1;
                    end
                end
                else if (sprtAccum < (ACC_LIMIT - ACC_STEP)) begin
                    sprtAccum <= sprtAccum + ACC_STEP;
                end
                else begin
                    sprtAccum <= ACC_LIMIT;
                    o_inSync  <= 1'b1;
                end
            end
        end
    end

    accumBounded: assert property (
        @(posedge clk) disable iff (reset)
        sprtAccum <= ACC_LIMIT
    ) else $error("SPRT accumulator above limit");

endmodule

//--- src/branchSyncTop.sv
`timescale 1ns/1ns

module branchSyncTop
    import viterbiSyncPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  demodMode_t  i_mode,
    input  symbol_t     i_sym,
    input  logic        i_symEn,
    input  errReport_t  i_err,
    output branchPair_t o_pair,
    output logic        o_pairValid,
    output syncStep_t   o_syncStep,
    output logic        o_inSync,
    output logic        o_slip
);

    // Slip request from the lock detector back to the aligner
    logic slip;

    branchAligner aligner (
        .clk         (clk),
        .reset       (reset),
        .i_mode      (i_mode),
        .i_sym       (i_sym),
        .i_symEn     (i_symEn),
        .i_slip      (slip),
        .o_pair      (o_pair),
        .o_pairValid (o_pairValid),
        .o_step      (o_syncStep)
    );

    sprtLockDetector lockDet (
        .clk      (clk),
        .reset    (reset),
        .i_err    (i_err),
        .o_inSync (o_inSync),
        .o_slip   (slip)
    );

    assign o_slip = slip;

endmodule

//--- sim/tbBranchSync.sv
`timescale 1ns/1ns

`include "viterbiSync_config.svh"

module tbBranchSync
    import viterbiSyncPkg::*;
();

    localparam int WAIT_LIMIT = 20;

    logic        clk;
    logic        reset = 1'b1;
    demodMode_t  mode = MODE_QPSK;
    symbol_t     sym = '0;
    logic        symEn = 1'b0;
    errReport_t  err = '0;
    branchPair_t pair;
    logic        pairValid;
    syncStep_t   syncStep;
    logic        inSync;
    logic        slip;

    integer seed = 32'h919f;

    // Expected state built from the stimulus
    syncStep_t              expStep;
    logic                   expPending;
    logic                   expCodeEn;
    logic [`SOFT_WIDTH-1:0] expPrevI;
    logic                   expValid;
    branchPair_t            expPair;
    int                     expAccum;
    logic                   expInSync;
    logic                   expSlip;
    logic                   stepOpen;

    branchSyncTop dut (
        .clk         (clk),
        .reset       (reset),
        .i_mode      (mode),
        .i_sym       (sym),
        .i_symEn     (symEn),
        .i_err       (err),
        .o_pair      (pair),
        .o_pairValid (pairValid),
        .o_syncStep  (syncStep),
        .o_inSync    (inSync),
        .o_slip      (slip)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    function automatic logic [`SOFT_WIDTH-1:0] hardSlice(input logic signed [`SYM_WIDTH-1:0] x);
        logic [`SOFT_WIDTH-1:0] level;
        if (x < 0) begin
            level = `SOFT_WIDTH'(`SOFT_NEG);
        end
        else begin
            level = `SOFT_WIDTH'(`SOFT_POS);
        end
        return level;
    endfunction

    // Rotation and inversion table per mode and step
    function automatic branchPair_t mapBranches(input demodMode_t m, input syncStep_t s,
            input logic [`SOFT_WIDTH-1:0] iNow, input logic [`SOFT_WIDTH-1:0] qNow,
            input logic [`SOFT_WIDTH-1:0] iBefore);
        branchPair_t p;
        p = '0;
        if (m == MODE_QPSK) begin
            case (s)
                STEP0, STEP4: begin
                    p.iG1 = iNow;
                    p.iG2 = qNow;
                end
                STEP1, STEP5: begin
                    p.iG1 = qNow;
                    p.iG2 = ~iNow;
                end
                STEP2, STEP6: begin
                    p.iG1 = ~iNow;
                    p.iG2 = ~qNow;
                end
                default: begin
                    p.iG1 = ~qNow;
                    p.iG2 = iNow;
                end
            endcase
        end
        else if (s inside {STEP0, STEP1, STEP4, STEP5}) begin
            p.iG1 = iBefore;
            p.iG2 = iNow;
        end
        else begin
            p.iG1 = ~iBefore;
            p.iG2 = ~iNow;
        end
        if (int'(s) >= 4) begin
            p.iG2 = ~p.iG2;
        end
        return p;
    endfunction

    function automatic logic pairDue(input demodMode_t m, input syncStep_t s, input logic phase);
        if (m == MODE_QPSK) begin
            return 1'b1;
        end
        return (int'(s) % 2 == 0) ? phase : !phase;
    endfunction

    assign stepOpen = symEn && ((mode == MODE_QPSK) || expCodeEn);

    always @(posedge clk) begin
        if (reset) begin
            expStep    <= STEP0;
            expPending <= 1'b0;
            expCodeEn  <= 1'b0;
            expValid   <= 1'b0;
            expAccum   <= `SPRT_START;
            expInSync  <= 1'b0;
            expSlip    <= 1'b0;
        end
        else begin
            expValid <= 1'b0;
            expSlip  <= 1'b0;
            if (mode == MODE_QPSK) begin
                expCodeEn <= 1'b1;
            end
            else if (symEn) begin
                expCodeEn <= !expCodeEn;
            end
            if (symEn) begin
                expPrevI <= hardSlice(sym.i);
                if (pairDue(mode, expStep, expCodeEn)) begin
                    expValid <= 1'b1;
                    expPair  <= mapBranches(mode, expStep, hardSlice(sym.i),
                                            hardSlice(sym.q), expPrevI);
                end
            end
            // Slip waits for a strobe on which a step may be taken
            if (expSlip || expPending) begin
                if (stepOpen) begin
                    expStep    <= syncStep_t'((int'(expStep) + 1) % 8);
                    expPending <= 1'b0;
                end
                else begin
                    expPending <= 1'b1;
                end
            end
            if (err.done && err.count == '0) begin
                if (expAccum < `SPRT_LIMIT - `SPRT_STEP) begin
                    expAccum <= expAccum + `SPRT_STEP;
                end
                else begin
                    expAccum  <= `SPRT_LIMIT;
                    expInSync <= 1'b1;
                end
            end
            else if (err.done && expAccum >= int'(err.count)) begin
                expAccum <= expAccum - int'(err.count);
            end
            else if (err.done) begin
                expAccum  <= `SPRT_START;
                expInSync <= 1'b0;
                expSlip   <= 1'b1;
            end
        end
    end

    resetState: assert property (
        @(posedge clk) $fell(reset) |->
            !pairValid && !slip && !inSync && syncStep == STEP0
    ) else abortRun($sformatf(
        "ERROR after reset o_pairValid=%h o_slip=%h o_inSync=%h o_syncStep=%h, expected 0 0 0 0",
        $sampled(pairValid), $sampled(slip), $sampled(inSync), $sampled(syncStep)));

    validCheck: assert property (
        @(posedge clk) disable iff (reset) pairValid == expValid
    ) else abortRun($sformatf("ERROR o_pairValid got %h expected %h",
        $sampled(pairValid), $sampled(expValid)));

    pairCheck: assert property (
        @(posedge clk) disable iff (reset) pairValid |-> pair == expPair
    ) else abortRun($sformatf("ERROR o_pair got %h expected %h",
        $sampled(pair), $sampled(expPair)));

    stepCheck: assert property (
        @(posedge clk) disable iff (reset) syncStep == expStep
    ) else abortRun($sformatf("ERROR o_syncStep got %h expected %h",
        $sampled(syncStep), $sampled(expStep)));

    slipCheck: assert property (
        @(posedge clk) disable iff (reset) slip == expSlip
    ) else abortRun($sformatf("ERROR o_slip got %h expected %h",
        $sampled(slip), $sampled(expSlip)));

    lockCheck: assert property (
        @(posedge clk) disable iff (reset) inSync == expInSync
    ) else abortRun($sformatf("ERROR o_inSync got %h expected %h",
        $sampled(inSync), $sampled(expInSync)));

    task automatic applyReset(input demodMode_t newMode);
        @(posedge clk);
        mode  <= newMode;
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic sendSymbol();
        logic [31:0] rawI;
        logic [31:0] rawQ;
        rawI = $random(seed);
        rawQ = $random(seed);
        @(posedge clk);
        sym   <= '{i: rawI[`SYM_WIDTH-1:0], q: rawQ[`SYM_WIDTH-1:0]};
        symEn <= 1'b1;
        @(posedge clk);
        symEn <= 1'b0;
    endtask

    task automatic sendReport(input logic [`BER_WIDTH-1:0] errors);
        @(posedge clk);
        err <= '{done: 1'b1, count: errors};
        @(posedge clk);
        err <= '{done: 1'b0, count: '0};
    endtask

    task automatic waitForSlip();
        int cycles;
        cycles = 0;
        while (slip !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abortRun("Timeout: no slip pulse after a failing error report");
            end
        end
    endtask

    task automatic waitForLock();
        int cycles;
        cycles = 0;
        while (inSync !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abortRun("Timeout: lock was never declared after clean reports");
            end
        end
    endtask

    task automatic waitForStep(input syncStep_t target);
        int cycles;
        cycles = 0;
        while (syncStep !== target) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abortRun($sformatf("Timeout: alignment step never reached %0d", target));
            end
        end
    endtask

    initial begin
        int k;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // QPSK pairs at STEP0
        repeat (8) sendSymbol();

        // Lock needs eight clean reports
        repeat (8) sendReport('0);
        waitForLock();

        // One slip per step with a wrap after STEP7
        for (k = 1; k <= 8; k++) begin
            sendReport(16'hFFFF);
            waitForSlip();
            repeat (6) sendSymbol();
            waitForStep(syncStep_t'(k % 8));
        end

        // BPSK and one slip to the other code phase
        applyReset(MODE_BPSK);
        repeat (8) sendSymbol();
        sendReport(16'hFFFF);
        waitForSlip();
        repeat (8) sendSymbol();
        waitForStep(STEP1);
        repeat (2) @(posedge clk);

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
src/viterbiSyncPkg.sv
src/branchAligner.sv
src/sprtLockDetector.sv
src/branchSyncTop.sv
sim/tbBranchSync.sv
